//--- Makefile
TOP := wbuf_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

//--- files.f
+incdir+src
src/wbuf_geom_pkg.sv
src/wbuf_ctrl_pkg.sv
src/wbuf_write_if.sv
src/wbuf_send_fifo.sv
src/wbuf_data_store.sv
src/wbuf_dir.sv
src/wbuf_top.sv
tb/wbuf_assert.sv
tb/wbuf_tb.sv

//--- src/wbuf_ctrl_pkg.sv
`include "wbuf_defs.svh"

package wbuf_ctrl_pkg;

    localparam int unsigned DIR_PTR_WIDTH  = $clog2(`WBUF_DIR_ENTRIES);
    localparam int unsigned DATA_PTR_WIDTH = $clog2(`WBUF_DATA_ENTRIES);

    // Life cycle of a directory entry
    typedef enum logic [1:0] {
        ENTRY_FREE = 2'b00,
        ENTRY_OPEN = 2'b01,  // collecting writes, timer running
        ENTRY_PEND = 2'b10,  // waiting for the send FIFOs
        ENTRY_SENT = 2'b11   // waiting for the memory ack
    } entry_state_e;

    typedef logic [DIR_PTR_WIDTH-1:0]       dir_ptr_t;
    typedef logic [DATA_PTR_WIDTH-1:0]      data_ptr_t;
    typedef logic [`WBUF_TIMECNT_WIDTH-1:0] timecnt_t;

    typedef struct packed {
        wbuf_geom_pkg::tag_t tag;
        data_ptr_t           ptr;
        timecnt_t            cnt;
    } dir_entry_t;

    // Address channel payload
    typedef struct packed {
        wbuf_geom_pkg::tag_t tag;
        dir_ptr_t            id;
    } send_meta_t;

    // Data channel payload
    typedef struct packed {
        data_ptr_t           ptr;
        wbuf_geom_pkg::tag_t tag;
    } send_data_t;

endpackage

//--- src/wbuf_data_store.sv
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_data_store (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    wbuf_write_if.store_mp           wr,
    input  wbuf_ctrl_pkg::data_ptr_t rd_ptr_i,
    input  logic                     rd_release_i,
    output wbuf_geom_pkg::line_t     rd_line_o,
    output wbuf_geom_pkg::line_be_t  rd_be_o
);

    localparam int unsigned ENTRIES = `WBUF_DATA_ENTRIES;
    localparam int unsigned BYTES   = `WBUF_WORD_WIDTH / 8;

    wbuf_geom_pkg::line_t     line_q [ENTRIES];
    wbuf_geom_pkg::line_be_t  be_q   [ENTRIES];
    logic [ENTRIES-1:0]       valid_q;
    wbuf_ctrl_pkg::data_ptr_t free_ptr_q, free_ptr_d;
    wbuf_geom_pkg::line_t     line_base, line_new;
    wbuf_geom_pkg::line_be_t  be_base, be_new;

    function automatic wbuf_ctrl_pkg::data_ptr_t next_free(
        input wbuf_ctrl_pkg::data_ptr_t cur,
        input logic [ENTRIES-1:0]       used
    );
        wbuf_ctrl_pkg::data_ptr_t idx;
        wbuf_ctrl_pkg::data_ptr_t res;
        res = cur;
        for (int i = ENTRIES - 1; i >= 1; i--) begin
            idx = wbuf_ctrl_pkg::data_ptr_t'((int'(cur) + i) % ENTRIES);
            if (!used[idx]) begin
                res = idx;
            end
        end
        return res;
    endfunction

    // New entries start from an empty line
    assign line_base = wr.wr_alloc ? '0 : line_q[wr.wr_ptr];
    assign be_base   = wr.wr_alloc ? '0 : be_q[wr.wr_ptr];

    always_comb begin
        line_new = line_base;
        be_new   = be_base;
        for (int b = 0; b < BYTES; b++) begin
            if (wr.wr_be[b]) begin
                line_new[wr.wr_word][b*8 +: 8] = wr.wr_data[b*8 +: 8];
            end
        end
        be_new[wr.wr_word] = be_base[wr.wr_word] | wr.wr_be;
    end

    always_ff @(posedge clk_i) begin
        if (wr.wr_valid) begin
            line_q[wr.wr_ptr] <= line_new;
            be_q[wr.wr_ptr]   <= be_new;
        end
    end

    // Released entry becomes the next allocation target
    always_comb begin
        free_ptr_d = free_ptr_q;
        if (rd_release_i) begin
            free_ptr_d = rd_ptr_i;
        end else if (wr.wr_valid && wr.wr_alloc) begin
            free_ptr_d = next_free(free_ptr_q, valid_q);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q    <= '0;
            free_ptr_q <= '0;
        end else begin
            if (wr.wr_valid && wr.wr_alloc) begin
                valid_q[wr.wr_ptr] <= 1'b1;
            end
            if (rd_release_i) begin
                valid_q[rd_ptr_i] <= 1'b0;
            end
            free_ptr_q <= free_ptr_d;
        end
    end

    assign wr.free_ptr = free_ptr_q;
    assign wr.free_ok  = !valid_q[free_ptr_q];
    assign rd_line_o   = line_q[rd_ptr_i];
    assign rd_be_o     = be_q[rd_ptr_i];

endmodule

//--- src/wbuf_defs.svh
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// Directory entries, each one tracks a buffered line
`define WBUF_DIR_ENTRIES 4

// Line data entries, also used as the depth of each send FIFO
`define WBUF_DATA_ENTRIES 4

// Write word geometry
`define WBUF_WORD_WIDTH 32
`define WBUF_WORDS 4

// Physical address width
`define WBUF_PA_WIDTH 32

// Timer counter and threshold width
`define WBUF_TIMECNT_WIDTH 4

`endif

//--- src/wbuf_dir.sv
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_dir (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      flush_all_i,
    input  wbuf_ctrl_pkg::timecnt_t   cfg_threshold_i,
    input  logic                      write_i,
    input  wbuf_geom_pkg::addr_t      write_addr_i,
    input  wbuf_geom_pkg::word_t      write_data_i,
    input  wbuf_geom_pkg::be_t        write_be_i,
    output logic                      write_ready_o,
    wbuf_write_if.dir_mp              wr,
    output logic                      meta_push_o,
    output wbuf_ctrl_pkg::send_meta_t meta_item_o,
    input  logic                      meta_full_i,
    output logic                      data_push_o,
    output wbuf_ctrl_pkg::send_data_t data_item_o,
    input  logic                      data_full_i,
    input  logic                      ack_i,
    input  wbuf_ctrl_pkg::dir_ptr_t   ack_id_i,
    output logic                      empty_o,
    output logic                      full_o
);

    localparam int unsigned ENTRIES = `WBUF_DIR_ENTRIES;

    wbuf_ctrl_pkg::entry_state_e [ENTRIES-1:0] state_q, state_d;
    wbuf_ctrl_pkg::dir_entry_t   [ENTRIES-1:0] dir_q, dir_d;
    wbuf_ctrl_pkg::dir_ptr_t                   free_ptr_q, free_ptr_d;
    wbuf_ctrl_pkg::dir_ptr_t                   send_ptr_q, send_ptr_d;
    wbuf_ctrl_pkg::dir_ptr_t                   hit_ptr;
    wbuf_ctrl_pkg::timecnt_t                   thr_m1;
    wbuf_geom_pkg::tag_t                       write_tag;
    logic [wbuf_geom_pkg::WORD_IDX_WIDTH-1:0]  write_word;
    logic                                      hit;
    logic                                      alloc_ok;
    logic                                      alloc;
    logic                                      push;

    // Round-robin search, nearest match after cur wins
    function automatic wbuf_ctrl_pkg::dir_ptr_t find_next(
        input wbuf_ctrl_pkg::dir_ptr_t                   cur,
        input wbuf_ctrl_pkg::entry_state_e [ENTRIES-1:0] st,
        input wbuf_ctrl_pkg::entry_state_e               want
    );
        wbuf_ctrl_pkg::dir_ptr_t idx;
        wbuf_ctrl_pkg::dir_ptr_t res;
        res = cur;
        for (int i = ENTRIES - 1; i >= 1; i--) begin
            idx = wbuf_ctrl_pkg::dir_ptr_t'((int'(cur) + i) % ENTRIES);
            if (st[idx] == want) begin
                res = idx;
            end
        end
        return res;
    endfunction

    assign write_tag  = wbuf_geom_pkg::tag_t'(write_addr_i >> wbuf_geom_pkg::OFFSET_WIDTH);
    assign write_word = write_addr_i[wbuf_geom_pkg::OFFSET_WIDTH-1:wbuf_geom_pkg::WORD_OFFSET];

    // Merge target, only lines not yet handed to the send FIFOs
    always_comb begin
        hit     = 1'b0;
        hit_ptr = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if ((state_q[i] == wbuf_ctrl_pkg::ENTRY_OPEN ||
                 state_q[i] == wbuf_ctrl_pkg::ENTRY_PEND) &&
                dir_q[i].tag == write_tag) begin
                hit     = 1'b1;
                hit_ptr = wbuf_ctrl_pkg::dir_ptr_t'(i);
            end
        end
    end

    assign alloc_ok      = (state_q[free_ptr_q] == wbuf_ctrl_pkg::ENTRY_FREE) && wr.free_ok && !hit;
    assign write_ready_o = hit || alloc_ok;
    assign alloc         = write_i && alloc_ok;

    // Store write port
    assign wr.wr_valid = write_i && write_ready_o;
    assign wr.wr_alloc = alloc;
    assign wr.wr_ptr   = hit ? dir_q[hit_ptr].ptr : wr.free_ptr;
    assign wr.wr_word  = write_word;
    assign wr.wr_data  = write_data_i;
    assign wr.wr_be    = write_be_i;

    assign thr_m1 = cfg_threshold_i - wbuf_ctrl_pkg::timecnt_t'(1);
    assign push   = (state_q[send_ptr_q] == wbuf_ctrl_pkg::ENTRY_PEND) &&
                    !meta_full_i && !data_full_i;

    always_comb begin
        state_d = state_q;
        dir_d   = dir_q;
        for (int i = 0; i < ENTRIES; i++) begin
            case (state_q[i])
                wbuf_ctrl_pkg::ENTRY_FREE: begin
                    if (alloc && free_ptr_q == wbuf_ctrl_pkg::dir_ptr_t'(i)) begin
                        state_d[i]   = (cfg_threshold_i == '0 || flush_all_i) ?
                                       wbuf_ctrl_pkg::ENTRY_PEND : wbuf_ctrl_pkg::ENTRY_OPEN;
                        dir_d[i].tag = write_tag;
                        dir_d[i].ptr = wr.free_ptr;
                        dir_d[i].cnt = '0;
                    end
                end
                wbuf_ctrl_pkg::ENTRY_OPEN: begin
                    if (flush_all_i || dir_q[i].cnt == thr_m1) begin
                        state_d[i] = wbuf_ctrl_pkg::ENTRY_PEND;
                    end else begin
                        dir_d[i].cnt = dir_q[i].cnt + 1'b1;
                    end
                end
                wbuf_ctrl_pkg::ENTRY_PEND: begin
                    if (push && send_ptr_q == wbuf_ctrl_pkg::dir_ptr_t'(i)) begin
                        state_d[i] = wbuf_ctrl_pkg::ENTRY_SENT;
                    end
                end
                default: begin
                    if (ack_i && ack_id_i == wbuf_ctrl_pkg::dir_ptr_t'(i)) begin
                        state_d[i] = wbuf_ctrl_pkg::ENTRY_FREE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        // An acked entry is free for sure, so jump straight to it
        free_ptr_d = free_ptr_q;
        if (ack_i) begin
            free_ptr_d = ack_id_i;
        end else if (alloc) begin
            free_ptr_d = find_next(free_ptr_q, state_q, wbuf_ctrl_pkg::ENTRY_FREE);
        end

        // Hold on a PEND entry until both FIFOs take it
        send_ptr_d = send_ptr_q;
        if (state_q[send_ptr_q] != wbuf_ctrl_pkg::ENTRY_PEND || push) begin
            send_ptr_d = find_next(send_ptr_q, state_q, wbuf_ctrl_pkg::ENTRY_PEND);
        end
    end

    assign meta_push_o     = push;
    assign data_push_o     = push;
    assign meta_item_o.tag = dir_q[send_ptr_q].tag;
    assign meta_item_o.id  = send_ptr_q;
    assign data_item_o.ptr = dir_q[send_ptr_q].ptr;
    assign data_item_o.tag = dir_q[send_ptr_q].tag;

    always_comb begin
        empty_o = 1'b1;
        full_o  = 1'b1;
        for (int i = 0; i < ENTRIES; i++) begin
            empty_o &= (state_q[i] == wbuf_ctrl_pkg::ENTRY_FREE);
            full_o  &= (state_q[i] != wbuf_ctrl_pkg::ENTRY_FREE);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < ENTRIES; i++) begin
                state_q[i] <= wbuf_ctrl_pkg::ENTRY_FREE;
            end
            free_ptr_q <= '0;
            send_ptr_q <= '0;
        end else begin
            state_q    <= state_d;
            free_ptr_q <= free_ptr_d;
            send_ptr_q <= send_ptr_d;
        end
    end

    always_ff @(posedge clk_i) begin
        dir_q <= dir_d;
    end

endmodule

//--- src/wbuf_geom_pkg.sv
`include "wbuf_defs.svh"

package wbuf_geom_pkg;

    // Byte offset of a line and of a word inside the line
    localparam int unsigned OFFSET_WIDTH   = $clog2((`WBUF_WORD_WIDTH * `WBUF_WORDS) / 8);
    localparam int unsigned WORD_OFFSET    = $clog2(`WBUF_WORD_WIDTH / 8);
    localparam int unsigned WORD_IDX_WIDTH = $clog2(`WBUF_WORDS);
    localparam int unsigned TAG_WIDTH      = `WBUF_PA_WIDTH - OFFSET_WIDTH;

    typedef logic [`WBUF_PA_WIDTH-1:0]     addr_t;
    typedef logic [TAG_WIDTH-1:0]          tag_t;
    typedef logic [`WBUF_WORD_WIDTH-1:0]   word_t;
    typedef logic [`WBUF_WORD_WIDTH/8-1:0] be_t;

    // Word 0 sits in the low bits of a line
    typedef word_t [`WBUF_WORDS-1:0] line_t;
    typedef be_t   [`WBUF_WORDS-1:0] line_be_t;

endpackage

//--- src/wbuf_send_fifo.sv
`timescale 1ns/1ps

module wbuf_send_fifo #(
    parameter type         item_t = logic,
    parameter int unsigned DEPTH  = 4
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  push_i,
    input  item_t item_i,
    output logic  full_o,
    input  logic  pop_i,
    output logic  valid_o,
    output item_t item_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    item_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign valid_o = (count_q != '0);
    assign item_o  = mem[rd_ptr_q];

    // Pop only from a stored item, so a push shows up one cycle later
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && valid_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= item_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- src/wbuf_top.sv
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_top (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    output logic                    empty_o,
    output logic                    full_o,
    input  logic                    flush_all_i,
    input  wbuf_ctrl_pkg::timecnt_t cfg_threshold_i,
    input  logic                    write_i,
    output logic                    write_ready_o,
    input  wbuf_geom_pkg::addr_t    write_addr_i,
    input  wbuf_geom_pkg::word_t    write_data_i,
    input  wbuf_geom_pkg::be_t      write_be_i,
    input  logic                    send_meta_ready_i,
    output logic                    send_meta_valid_o,
    output wbuf_geom_pkg::addr_t    send_addr_o,
    output wbuf_ctrl_pkg::dir_ptr_t send_id_o,
    input  logic                    send_data_ready_i,
    output logic                    send_data_valid_o,
    output wbuf_geom_pkg::addr_t    send_data_addr_o,
    output wbuf_geom_pkg::line_t    send_data_o,
    output wbuf_geom_pkg::line_be_t send_be_o,
    input  logic                    ack_i,
    input  wbuf_ctrl_pkg::dir_ptr_t ack_id_i
);

    wbuf_write_if wr ();

    logic                      meta_push, meta_full;
    logic                      data_push, data_full;
    logic                      data_release;
    wbuf_ctrl_pkg::send_meta_t meta_item, meta_head;
    wbuf_ctrl_pkg::send_data_t data_item, data_head;

    wbuf_dir dir_inst (
        .clk_i, .rst_ni, .flush_all_i, .cfg_threshold_i,
        .write_i, .write_addr_i, .write_data_i, .write_be_i, .write_ready_o,
        .wr          (wr),
        .meta_push_o (meta_push),
        .meta_item_o (meta_item),
        .meta_full_i (meta_full),
        .data_push_o (data_push),
        .data_item_o (data_item),
        .data_full_i (data_full),
        .ack_i, .ack_id_i, .empty_o, .full_o
    );

    // Address channel
    wbuf_send_fifo #(.item_t(wbuf_ctrl_pkg::send_meta_t), .DEPTH(`WBUF_DATA_ENTRIES)) meta_fifo_inst (
        .clk_i, .rst_ni,
        .push_i  (meta_push),
        .item_i  (meta_item),
        .full_o  (meta_full),
        .pop_i   (send_meta_ready_i),
        .valid_o (send_meta_valid_o),
        .item_o  (meta_head)
    );

    // Data channel, its head addresses the store read port
    wbuf_send_fifo #(.item_t(wbuf_ctrl_pkg::send_data_t), .DEPTH(`WBUF_DATA_ENTRIES)) data_fifo_inst (
        .clk_i, .rst_ni,
        .push_i  (data_push),
        .item_i  (data_item),
        .full_o  (data_full),
        .pop_i   (send_data_ready_i),
        .valid_o (send_data_valid_o),
        .item_o  (data_head)
    );

    assign data_release = send_data_valid_o && send_data_ready_i;

    wbuf_data_store store_inst (
        .clk_i, .rst_ni,
        .wr           (wr),
        .rd_ptr_i     (data_head.ptr),
        .rd_release_i (data_release),
        .rd_line_o    (send_data_o),
        .rd_be_o      (send_be_o)
    );

    // Line addresses have zero offset bits
    assign send_addr_o      = {meta_head.tag, {wbuf_geom_pkg::OFFSET_WIDTH{1'b0}}};
    assign send_id_o        = meta_head.id;
    assign send_data_addr_o = {data_head.tag, {wbuf_geom_pkg::OFFSET_WIDTH{1'b0}}};

endmodule

//--- src/wbuf_write_if.sv
`timescale 1ns/1ps

interface wbuf_write_if;

    // Write into the line data array, applied on the same rising edge
    logic                                     wr_valid;
    logic                                     wr_alloc;
    wbuf_ctrl_pkg::data_ptr_t                 wr_ptr;
    logic [wbuf_geom_pkg::WORD_IDX_WIDTH-1:0] wr_word;
    wbuf_geom_pkg::word_t                     wr_data;
    wbuf_geom_pkg::be_t                       wr_be;

    // Next free data entry, as seen by the store
    wbuf_ctrl_pkg::data_ptr_t                 free_ptr;
    logic                                     free_ok;

    modport dir_mp (
        output wr_valid, wr_alloc, wr_ptr, wr_word, wr_data, wr_be,
        input  free_ptr, free_ok
    );

    modport store_mp (
        input  wr_valid, wr_alloc, wr_ptr, wr_word, wr_data, wr_be,
        output free_ptr, free_ok
    );

endinterface

//--- tb/wbuf_assert.sv
`timescale 1ns/1ps
`include "wbuf_defs.svh"

module wbuf_assert (
    input logic                                                 clk_i,
    input logic                                                 rst_ni,
    input wbuf_ctrl_pkg::entry_state_e [`WBUF_DIR_ENTRIES-1:0] state_i,
    input wbuf_ctrl_pkg::dir_ptr_t                              send_ptr_i,
    input logic                                                 ack_i,
    input wbuf_ctrl_pkg::dir_ptr_t                              ack_id_i,
    input logic                                                 meta_push_i,
    input logic                                                 data_push_i,
    input wbuf_ctrl_pkg::data_ptr_t                             data_ptr_i,
    input wbuf_ctrl_pkg::data_ptr_t                             free_ptr_i,
    input logic                                                 free_ok_i
);

    // Memory only acknowledges lines that were handed out
    ack_of_sent: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ack_i |-> state_i[ack_id_i] == wbuf_ctrl_pkg::ENTRY_SENT)
        else $error("ack names a directory entry that is not in the SENT state");

    // A pushed entry was PEND and then waits for its ack
    meta_from_pend: assert property (@(posedge clk_i) disable iff (!rst_ni)
        meta_push_i |=> $past(state_i[send_ptr_i]) == wbuf_ctrl_pkg::ENTRY_PEND &&
                        state_i[$past(send_ptr_i)] == wbuf_ctrl_pkg::ENTRY_SENT)
        else $error("address channel push did not move a PEND entry to SENT");

    // The line being pushed still owns its data entry
    data_with_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_push_i |-> !(free_ok_i && free_ptr_i == data_ptr_i))
        else $error("data channel push names a data entry that the store holds free");

endmodule

//--- tb/wbuf_patterns.txt
# op addr word be line line_be, all hex, unused fields 0
# op 1 threshold, 2 write, 3 flush, 4 expect send, 5 ack, 6 status {empty,full,ready}, 7 hold
# Three writes merge into one line
1 0 f 0 0 0
2 1000 11223344 f 0 0
2 1004 aabbccdd 3 0 0
2 1000 55667788 6 0 0
3 0 0 0 0 0
4 1000 0 0 00000000000000000000ccdd11667744 003f
5 0 0 0 0 0
# Zero threshold sends at once, address rounded to the line
1 0 0 0 0 0
2 3008 01020304 9 0 0
4 3000 0 0 00000000010000040000000000000000 0900
5 0 0 0 0 0
# Flush of three held lines
1 0 f 0 0 0
2 400c 44444444 f 0 0
2 5004 55555555 f 0 0
2 6000 66666666 1 0 0
3 0 0 0 0 0
4 4000 0 0 44444444000000000000000000000000 f000
4 5000 0 0 00000000000000005555555500000000 00f0
4 6000 0 0 00000000000000000000000000000066 0001
5 0 0 0 0 0
5 0 0 0 0 0
5 0 0 0 0 0
# Four lines fill the buffer
1 0 f 0 0 0
2 7000 70707070 f 0 0
2 8000 80808080 f 0 0
2 9000 90909090 f 0 0
2 a000 a0a0a0a0 f 0 0
6 b000 2 0 0 0
3 0 0 0 0 0
4 7000 0 0 00000000000000000000000070707070 000f
4 8000 0 0 00000000000000000000000080808080 000f
4 9000 0 0 00000000000000000000000090909090 000f
4 a000 0 0 000000000000000000000000a0a0a0a0 000f
5 0 0 0 0 0
5 0 0 0 0 0
5 0 0 0 0 0
5 0 0 0 0 0
6 b000 5 0 0 0
# Back-pressure, then sends in write order
1 0 0 0 0 0
2 c000 c0c0c0c0 f 0 0
2 d000 d0d0d0d0 f 0 0
2 e000 e0e0e0e0 f 0 0
7 0 8 0 0 0
4 c000 0 0 000000000000000000000000c0c0c0c0 000f
4 d000 0 0 000000000000000000000000d0d0d0d0 000f
4 e000 0 0 000000000000000000000000e0e0e0e0 000f
5 0 0 0 0 0
5 0 0 0 0 0
5 0 0 0 0 0
6 b000 5 0 0 0

//--- tb/wbuf_tb.sv
`timescale 1ns/1ps

module wbuf_tb;

    localparam int TIMEOUT_CYCLES    = 100;
    localparam int FLUSH_SEND_CYCLES = 4;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    empty_o;
    logic                    full_o;
    logic                    flush_all_i;
    wbuf_ctrl_pkg::timecnt_t cfg_threshold_i;
    logic                    write_i;
    logic                    write_ready_o;
    wbuf_geom_pkg::addr_t    write_addr_i;
    wbuf_geom_pkg::word_t    write_data_i;
    wbuf_geom_pkg::be_t      write_be_i;
    logic                    send_meta_ready_i;
    logic                    send_meta_valid_o;
    wbuf_geom_pkg::addr_t    send_addr_o;
    wbuf_ctrl_pkg::dir_ptr_t send_id_o;
    logic                    send_data_ready_i;
    logic                    send_data_valid_o;
    wbuf_geom_pkg::addr_t    send_data_addr_o;
    wbuf_geom_pkg::line_t    send_data_o;
    wbuf_geom_pkg::line_be_t send_be_o;
    logic                    ack_i;
    wbuf_ctrl_pkg::dir_ptr_t ack_id_i;

    // Reference lines still waiting for their send
    wbuf_geom_pkg::tag_t     model_tag[$];
    wbuf_geom_pkg::line_t    model_line[$];
    wbuf_geom_pkg::line_be_t model_be[$];
    wbuf_ctrl_pkg::dir_ptr_t sent_ids[$];

    int errors;
    int timeouts;
    int send_limit;

    wbuf_top wbuf_top_inst (.*);

    bind wbuf_dir wbuf_assert assert_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .state_i     (state_q),
        .send_ptr_i  (send_ptr_q),
        .ack_i       (ack_i),
        .ack_id_i    (ack_id_i),
        .meta_push_i (meta_push_o),
        .data_push_i (data_push_o),
        .data_ptr_i  (data_item_o.ptr),
        .free_ptr_i  (wr.free_ptr),
        .free_ok_i   (wr.free_ok)
    );

    always #5 clk_i = ~clk_i;

    task automatic compare(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    function automatic int find_line(input wbuf_geom_pkg::tag_t tag);
        for (int i = 0; i < model_tag.size(); i++) begin
            if (model_tag[i] == tag) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Later bytes win, byte enables accumulate
    task automatic model_merge(input wbuf_geom_pkg::addr_t addr, input wbuf_geom_pkg::word_t data,
                               input wbuf_geom_pkg::be_t be);
        wbuf_geom_pkg::line_t    line;
        wbuf_geom_pkg::line_be_t lbe;
        int                      idx;
        int                      word;
        idx  = find_line(wbuf_geom_pkg::tag_t'(addr >> 4));
        word = int'(addr[3:2]);
        if (idx < 0) begin
            model_tag.push_back(wbuf_geom_pkg::tag_t'(addr >> 4));
            model_line.push_back('0);
            model_be.push_back('0);
            idx = model_tag.size() - 1;
        end
        line = model_line[idx];
        lbe  = model_be[idx];
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                line[word][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        lbe[word]       = lbe[word] | be;
        model_line[idx] = line;
        model_be[idx]   = lbe;
    endtask

    task automatic apply_write(input wbuf_geom_pkg::addr_t addr, input wbuf_geom_pkg::word_t data,
                               input wbuf_geom_pkg::be_t be);
        int waited;
        waited       = 0;
        // A new line may wait for its timer again
        send_limit   = TIMEOUT_CYCLES;
        write_i      = 1'b1;
        write_addr_i = addr;
        write_data_i = data;
        write_be_i   = be;
        #1;
        while (!write_ready_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            #1;
            waited++;
        end
        if (!write_ready_o) begin
            timeouts++;
            $display("timeout at %0t: write to %h was never accepted", $time, addr);
        end else begin
            model_merge(addr, data, be);
        end
        @(negedge clk_i);
        write_i = 1'b0;
    endtask

    // Flushed lines go out within a few cycles
    task automatic pulse_flush();
        flush_all_i = 1'b1;
        send_limit  = FLUSH_SEND_CYCLES;
        @(negedge clk_i);
        flush_all_i = 1'b0;
    endtask

    task automatic expect_send(input wbuf_geom_pkg::addr_t addr, input wbuf_geom_pkg::line_t line,
                               input wbuf_geom_pkg::line_be_t be);
        int waited;
        int idx;
        waited = 0;
        while (!(send_meta_valid_o && send_data_valid_o) && waited < send_limit) begin
            @(negedge clk_i);
            waited++;
        end
        if (!(send_meta_valid_o && send_data_valid_o)) begin
            timeouts++;
            $display("timeout at %0t: line %h was never sent", $time, addr);
        end else begin
            compare("send_addr_o", send_addr_o, addr);
            compare("send_data_addr_o", send_data_addr_o, addr);
            compare("send_data_o", send_data_o, line);
            compare("send_be_o", send_be_o, be);
            // Record must agree with the merged reference line
            idx = find_line(wbuf_geom_pkg::tag_t'(addr >> 4));
            if (idx < 0) begin
                errors++;
                $display("sent line %h at %0t was never written", addr, $time);
            end else begin
                compare("model line", model_line[idx], line);
                compare("model byte enables", model_be[idx], be);
                model_tag.delete(idx);
                model_line.delete(idx);
                model_be.delete(idx);
            end
            // An entry holds one line until its ack
            foreach (sent_ids[i]) begin
                if (sent_ids[i] == send_id_o) begin
                    errors++;
                    $display("send_id_o %0d at %0t is still waiting for its ack",
                             send_id_o, $time);
                end
            end
            sent_ids.push_back(send_id_o);
            send_meta_ready_i = 1'b1;
            send_data_ready_i = 1'b1;
            @(negedge clk_i);
            send_meta_ready_i = 1'b0;
            send_data_ready_i = 1'b0;
        end
    endtask

    task automatic send_ack();
        if (sent_ids.size() == 0) begin
            errors++;
            $display("ack at %0t with no send waiting for one", $time);
        end else begin
            ack_i    = 1'b1;
            ack_id_i = sent_ids.pop_front();
            @(negedge clk_i);
            ack_i = 1'b0;
        end
    endtask

    // Expected bits are {empty, full, ready for the probe address}
    task automatic check_status(input wbuf_geom_pkg::addr_t probe, input logic [2:0] expected);
        write_addr_i = probe;
        #1;
        compare("empty_o", empty_o, expected[2]);
        compare("full_o", full_o, expected[1]);
        compare("write_ready_o", write_ready_o, expected[0]);
        @(negedge clk_i);
    endtask

    task automatic hold_back(input int cycles);
        int                   waited;
        wbuf_geom_pkg::addr_t addr0;
        wbuf_geom_pkg::line_t line0;
        waited = 0;
        while (!send_meta_valid_o && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!send_meta_valid_o) begin
            timeouts++;
            $display("timeout at %0t: no send appeared under back-pressure", $time);
        end else begin
            addr0 = send_addr_o;
            line0 = send_data_o;
            repeat (cycles) begin
                @(negedge clk_i);
                compare("send_meta_valid_o", send_meta_valid_o, 1'b1);
                compare("send_data_valid_o", send_data_valid_o, 1'b1);
                compare("send_addr_o", send_addr_o, addr0);
                compare("send_data_o", send_data_o, line0);
            end
        end
    endtask

    initial begin
        int           fd;
        int           n;
        int           records;
        string        text;
        logic [3:0]   op;
        logic [31:0]  addr;
        logic [31:0]  word;
        logic [3:0]   be;
        logic [127:0] exp_line;
        logic [15:0]  exp_be;

        errors            = 0;
        timeouts          = 0;
        records           = 0;
        send_limit        = TIMEOUT_CYCLES;
        clk_i             = 1'b0;
        rst_ni            = 1'b0;
        flush_all_i       = 1'b0;
        cfg_threshold_i   = '0;
        write_i           = 1'b0;
        write_addr_i      = '0;
        write_data_i      = '0;
        write_be_i        = '0;
        send_meta_ready_i = 1'b0;
        send_data_ready_i = 1'b0;
        ack_i             = 1'b0;
        ack_id_i          = '0;

        repeat (4) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        compare("empty_o", empty_o, 1'b1);
        compare("full_o", full_o, 1'b0);
        compare("send_meta_valid_o", send_meta_valid_o, 1'b0);
        compare("send_data_valid_o", send_data_valid_o, 1'b0);
        @(negedge clk_i);

        fd = $fopen("tb/wbuf_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open tb/wbuf_patterns.txt");
        end else begin
            while ($fgets(text, fd) != 0) begin
                n = $sscanf(text, "%h %h %h %h %h %h", op, addr, word, be, exp_line, exp_be);
                // Comment and blank lines do not scan
                if (n == 6) begin
                    records++;
                    case (op)
                        4'h1: cfg_threshold_i = word[3:0];
                        4'h2: apply_write(addr, word, be);
                        4'h3: pulse_flush();
                        4'h4: expect_send(addr, exp_line, exp_be);
                        4'h5: send_ack();
                        4'h6: check_status(addr, word[2:0]);
                        4'h7: hold_back(int'(word));
                        default: begin
                            errors++;
                            $display("unknown operation %h in the pattern file", op);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        if (records == 0) begin
            errors++;
            $display("the pattern file held no records");
        end
        if (model_tag.size() != 0) begin
            errors++;
            $display("%0d written lines were never sent", model_tag.size());
        end

        $display("errors: %0d mismatches, %0d timeouts, %0d records run", errors, timeouts, records);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
